//--- lsu_iq_cfg.svh
`ifndef LSU_IQ_CFG_SVH
`define LSU_IQ_CFG_SVH

// queue slots, keep a power of two
`define LSU_IQ_DEPTH 8

// physical register number width
`define LSU_PREG_W 6

// writeback wakeup ports
`define LSU_WAKE_PORTS 4

`endif

//--- uop_pkg.sv
`include "lsu_iq_cfg.svh"

package uop_pkg;

    typedef logic [`LSU_PREG_W-1:0] preg_t;

    typedef enum logic [1:0] {
        MEM_B = 2'd0,
        MEM_H = 2'd1,
        MEM_W = 2'd2,
        MEM_D = 2'd3
    } mem_size_e;

    // load view of the memory-control word
    typedef struct packed {
        mem_size_e   size;
        logic        zext;     // unsigned load
        logic        rsvd;
        logic [11:0] offset;
    } ld_ctrl_t;

    // store view, same size and offset fields
    typedef struct packed {
        mem_size_e   size;
        logic        rel;      // release ordering
        logic        rsvd;
        logic [11:0] offset;
    } st_ctrl_t;

    // decoded by is_store
    typedef union packed {
        ld_ctrl_t ld;
        st_ctrl_t st;
    } mem_ctrl_u;

    typedef struct packed {
        logic        is_store;
        preg_t       prs1;
        preg_t       prs2;
        preg_t       pdst;
        logic        dst_we;
        logic [5:0]  rob_tag;
        mem_ctrl_u   mem_ctrl;
    } uop_t;

endpackage

//--- iq_pkg.sv
`include "lsu_iq_cfg.svh"

package iq_pkg;

    // slot index
    typedef logic [$clog2(`LSU_IQ_DEPTH)-1:0] iq_idx_t;

    // occupancy, one extra bit so a full queue fits
    typedef logic [$clog2(`LSU_IQ_DEPTH):0] iq_cnt_t;

endpackage

//--- lsu_iq_entry.sv
`timescale 1ns/100ps
`include "lsu_iq_cfg.svh"

module lsu_iq_entry import uop_pkg::*; (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic                                      flush,
    input  logic                                      enq_en,
    input  logic                                      enq_sel,
    input  logic                                      cmp_en,
    input  uop_t                                      uop_0,
    input  uop_t                                      uop_1,
    input  uop_t                                      up_uop,
    input  logic                                      prs1_rdy_0,
    input  logic                                      prs2_rdy_0,
    input  logic                                      prs1_rdy_1,
    input  logic                                      prs2_rdy_1,
    input  logic                                      up_prs1_rdy,
    input  logic                                      up_prs2_rdy,
    input  logic [`LSU_WAKE_PORTS-1:0]                wake_en,
    input  logic [`LSU_WAKE_PORTS*`LSU_PREG_W-1:0]    wake_preg,
    output uop_t                                      uop,
    output logic                                      prs1_rdy,
    output logic                                      prs2_rdy,
    output logic                                      rdy,
    output logic                                      is_store
);

    uop_t nxt_uop;
    logic nxt_r1;
    logic nxt_r2;
    logic wake1;
    logic wake2;

    // new uop wins over shifting down, otherwise hold
    always_comb begin
        nxt_uop = uop;
        nxt_r1  = prs1_rdy;
        nxt_r2  = prs2_rdy;
        if (enq_en) begin
            nxt_uop = enq_sel ? uop_1 : uop_0;
            nxt_r1  = enq_sel ? prs1_rdy_1 : prs1_rdy_0;
            nxt_r2  = enq_sel ? prs2_rdy_1 : prs2_rdy_0;
        end else if (cmp_en) begin
            nxt_uop = up_uop;
            nxt_r1  = up_prs1_rdy;
            nxt_r2  = up_prs2_rdy;
        end
    end

    // match against whatever lands here next cycle
    always_comb begin
        wake1 = 1'b0;
        wake2 = 1'b0;
        for (int p = 0; p < `LSU_WAKE_PORTS; p++) begin
            if (wake_en[p] && wake_preg[p*`LSU_PREG_W +: `LSU_PREG_W] == nxt_uop.prs1)
                wake1 = 1'b1;
            if (wake_en[p] && wake_preg[p*`LSU_PREG_W +: `LSU_PREG_W] == nxt_uop.prs2)
                wake2 = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        uop <= nxt_uop;
        if (rst || flush) begin
            prs1_rdy <= 1'b0;
            prs2_rdy <= 1'b0;
        end else begin
            prs1_rdy <= nxt_r1 | wake1;
            prs2_rdy <= nxt_r2 | wake2;
        end
    end

    assign rdy      = prs1_rdy & prs2_rdy;
    assign is_store = uop.is_store;

    // controller keeps enqueue targets above the compaction range
    a_no_conflict: assert property (@(posedge clk) disable iff (rst) !(enq_en && cmp_en));

endmodule

//--- lsu_iq_ctrl.sv
`timescale 1ns/100ps
`include "lsu_iq_cfg.svh"

module lsu_iq_ctrl import iq_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       flush,
    input  logic                       enq_req_0,
    input  logic                       enq_req_1,
    input  logic                       deq,
    input  iq_idx_t                    deq_idx,
    output logic [`LSU_IQ_DEPTH-1:0]   enq_en,
    output logic [`LSU_IQ_DEPTH-1:0]   enq_sel,
    output logic [`LSU_IQ_DEPTH-1:0]   cmp_en,
    output logic [`LSU_IQ_DEPTH-1:0]   valid_vec,
    output logic                       ready
);

    iq_cnt_t tail;
    iq_cnt_t pos0;
    iq_cnt_t pos1;
    logic    freeze;
    logic    enq_0;
    logic    enq_1;

    // two free slots needed to accept a pair
    assign freeze = tail >= iq_cnt_t'(`LSU_IQ_DEPTH - 1);
    assign ready  = ~freeze;

    assign enq_0 = enq_req_0 & ~freeze & ~flush;
    assign enq_1 = enq_req_1 & enq_0;   // slot 1 only rides with slot 0

    // write positions after the dequeue shift
    assign pos0 = tail - iq_cnt_t'(deq);
    assign pos1 = pos0 + iq_cnt_t'(1);

    always_comb begin
        for (int i = 0; i < `LSU_IQ_DEPTH; i++) begin
            enq_en[i]    = (enq_0 && pos0 == iq_cnt_t'(i)) ||
                           (enq_1 && pos1 == iq_cnt_t'(i));
            enq_sel[i]   = pos0 != iq_cnt_t'(i);
            // only slots whose upper neighbor holds a live entry
            cmp_en[i]    = deq && i >= int'(deq_idx) && i + 1 < int'(tail);
            valid_vec[i] = i < int'(tail);
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            tail <= '0;
        end else begin
            tail <= tail + iq_cnt_t'(enq_0) + iq_cnt_t'(enq_1) - iq_cnt_t'(deq);
        end
    end

    a_tail_bound: assert property (
        @(posedge clk) disable iff (rst)
        tail <= iq_cnt_t'(`LSU_IQ_DEPTH)
    );

    // arbiter must never pick from an empty queue
    a_deq_nonempty: assert property (
        @(posedge clk) disable iff (rst)
        deq |-> tail != '0
    );

endmodule

//--- lsu_store_order.sv
`timescale 1ns/100ps
`include "lsu_iq_cfg.svh"

module lsu_store_order (
    input  logic [`LSU_IQ_DEPTH-1:0] valid_vec,
    input  logic [`LSU_IQ_DEPTH-1:0] slot_is_store,
    output logic [`LSU_IQ_DEPTH-1:0] issue_ok
);

    logic older_store;

    // walk from oldest, block everything behind the first live store
    always_comb begin
        older_store = 1'b0;
        for (int i = 0; i < `LSU_IQ_DEPTH; i++) begin
            issue_ok[i] = ~older_store;
            older_store = older_store | (valid_vec[i] & slot_is_store[i]);
        end
    end

endmodule

//--- lsu_issue_arbiter.sv
`timescale 1ns/100ps
`include "lsu_iq_cfg.svh"

module lsu_issue_arbiter import iq_pkg::*; (
    input  logic [`LSU_IQ_DEPTH-1:0] req_vec,
    output iq_idx_t                  sel_idx,
    output logic                     sel_valid
);

    // scan down so index 0 is written last and wins
    always_comb begin
        sel_idx = '0;
        for (int i = `LSU_IQ_DEPTH - 1; i >= 0; i--) begin
            if (req_vec[i])
                sel_idx = iq_idx_t'(i);
        end
    end

    assign sel_valid = |req_vec;

endmodule

//--- lsu_issue_unit.sv
`timescale 1ns/100ps
`include "lsu_iq_cfg.svh"

module lsu_issue_unit import uop_pkg::*, iq_pkg::*; (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic                                      flush,
    input  logic                                      enq_req_0,
    input  logic                                      enq_req_1,
    input  uop_t                                      uop_0,
    input  uop_t                                      uop_1,
    input  logic                                      prs1_rdy_0,
    input  logic                                      prs2_rdy_0,
    input  logic                                      prs1_rdy_1,
    input  logic                                      prs2_rdy_1,
    input  logic [`LSU_WAKE_PORTS-1:0]                wake_en,
    input  logic [`LSU_WAKE_PORTS*`LSU_PREG_W-1:0]    wake_preg,
    input  logic                                      lsu_busy,
    output logic                                      ready,
    output logic                                      issue_en,
    output uop_t                                      issue_uop
);

    logic [`LSU_IQ_DEPTH-1:0] enq_en;
    logic [`LSU_IQ_DEPTH-1:0] enq_sel;
    logic [`LSU_IQ_DEPTH-1:0] cmp_en;
    logic [`LSU_IQ_DEPTH-1:0] valid_vec;
    logic [`LSU_IQ_DEPTH-1:0] slot_rdy;
    logic [`LSU_IQ_DEPTH-1:0] slot_is_store;
    logic [`LSU_IQ_DEPTH-1:0] issue_ok;
    iq_idx_t                  sel_idx;
    logic                     sel_valid;

    // one extra element, the empty neighbor of the top slot
    uop_t slot_uop [0:`LSU_IQ_DEPTH];
    logic slot_r1  [0:`LSU_IQ_DEPTH];
    logic slot_r2  [0:`LSU_IQ_DEPTH];

    assign slot_uop[`LSU_IQ_DEPTH] = '0;
    assign slot_r1[`LSU_IQ_DEPTH]  = 1'b0;
    assign slot_r2[`LSU_IQ_DEPTH]  = 1'b0;

    lsu_iq_ctrl u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .enq_req_0 (enq_req_0),
        .enq_req_1 (enq_req_1),
        .deq       (sel_valid),
        .deq_idx   (sel_idx),
        .enq_en    (enq_en),
        .enq_sel   (enq_sel),
        .cmp_en    (cmp_en),
        .valid_vec (valid_vec),
        .ready     (ready)
    );

    for (genvar i = 0; i < `LSU_IQ_DEPTH; i++) begin : g_slot
        lsu_iq_entry u_entry (
            .clk         (clk),
            .rst         (rst),
            .flush       (flush),
            .enq_en      (enq_en[i]),
            .enq_sel     (enq_sel[i]),
            .cmp_en      (cmp_en[i]),
            .uop_0       (uop_0),
            .uop_1       (uop_1),
            .up_uop      (slot_uop[i+1]),
            .prs1_rdy_0  (prs1_rdy_0),
            .prs2_rdy_0  (prs2_rdy_0),
            .prs1_rdy_1  (prs1_rdy_1),
            .prs2_rdy_1  (prs2_rdy_1),
            .up_prs1_rdy (slot_r1[i+1]),
            .up_prs2_rdy (slot_r2[i+1]),
            .wake_en     (wake_en),
            .wake_preg   (wake_preg),
            .uop         (slot_uop[i]),
            .prs1_rdy    (slot_r1[i]),
            .prs2_rdy    (slot_r2[i]),
            .rdy         (slot_rdy[i]),
            .is_store    (slot_is_store[i])
        );
    end

    lsu_store_order u_order (
        .valid_vec     (valid_vec),
        .slot_is_store (slot_is_store),
        .issue_ok      (issue_ok)
    );

    lsu_issue_arbiter u_arb (
        .req_vec   (slot_rdy & valid_vec & issue_ok & {`LSU_IQ_DEPTH{~lsu_busy}}),
        .sel_idx   (sel_idx),
        .sel_valid (sel_valid)
    );

    assign issue_en  = sel_valid;
    assign issue_uop = slot_uop[sel_idx];   // same-cycle issue mux

endmodule

//--- tb_lsu_issue_unit.sv
`timescale 1ns/100ps
`include "lsu_iq_cfg.svh"

module tb_lsu_issue_unit import uop_pkg::*; ();

    localparam int D = `LSU_IQ_DEPTH;
    localparam int W = `LSU_PREG_W;

    logic clk, rst, flush, enq_req_0, enq_req_1, lsu_busy;
    logic prs1_rdy_0, prs2_rdy_0, prs1_rdy_1, prs2_rdy_1;
    logic [`LSU_WAKE_PORTS-1:0]   wake_en;
    logic [`LSU_WAKE_PORTS*W-1:0] wake_preg;
    uop_t uop_0, uop_1, issue_uop;
    logic ready, issue_en;
    integer seed = 32'h155d_1b89;

    // reference queue, index 0 oldest
    uop_t m_uop [0:D-1];
    logic m_r1  [0:D-1];
    logic m_r2  [0:D-1];
    int   m_cnt = 0;
    logic exp_en, exp_ready, st_seen, take0, take1, sel_en;
    int   exp_idx, sel;
    uop_t exp_uop;

    lsu_issue_unit u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // oldest ready entry not behind a store
    always_comb begin
        exp_en  = 1'b0;
        exp_idx = 0;
        st_seen = 1'b0;
        for (int i = 0; i < D; i++) begin
            if (i < m_cnt && !exp_en && !st_seen && m_r1[i] && m_r2[i] && !lsu_busy) begin
                exp_en  = 1'b1;
                exp_idx = i;
            end
            if (i < m_cnt && m_uop[i].is_store)
                st_seen = 1'b1;
        end
        exp_uop   = m_uop[exp_idx];
        exp_ready = m_cnt <= D - 2;
    end

    always @(posedge clk) begin
        if (rst || flush) begin
            m_cnt = 0;
        end else begin
            take0  = enq_req_0 && m_cnt < D - 1;   // frozen requests are dropped
            take1  = take0 && enq_req_1;
            sel_en = exp_en;
            sel    = exp_idx;
            if (sel_en) begin
                for (int i = sel; i < m_cnt - 1; i++) begin
                    m_uop[i] = m_uop[i+1];
                    m_r1[i]  = m_r1[i+1];
                    m_r2[i]  = m_r2[i+1];
                end
                m_cnt = m_cnt - 1;
            end
            if (take0) begin
                m_uop[m_cnt] = uop_0;
                m_r1[m_cnt]  = prs1_rdy_0;
                m_r2[m_cnt]  = prs2_rdy_0;
                m_cnt = m_cnt + 1;
            end
            if (take1) begin
                m_uop[m_cnt] = uop_1;
                m_r1[m_cnt]  = prs1_rdy_1;
                m_r2[m_cnt]  = prs2_rdy_1;
                m_cnt = m_cnt + 1;
            end
            for (int i = 0; i < m_cnt; i++) begin
                for (int p = 0; p < `LSU_WAKE_PORTS; p++) begin
                    if (wake_en[p] && wake_preg[p*W +: W] == m_uop[i].prs1)
                        m_r1[i] = 1'b1;
                    if (wake_en[p] && wake_preg[p*W +: W] == m_uop[i].prs2)
                        m_r2[i] = 1'b1;
                end
            end
        end
    end

    task automatic report_mismatch(input string name, input logic [63:0] got, exp);
        $display("*** FAILED ***");
        $display("[ERROR] %s: got %h, expected %h", name, got, exp);
        $fatal(1, "mismatch on %s", name);
    endtask

    // checked mid-cycle where everything has settled
    a_issue_en: assert property (@(negedge clk) disable iff (rst) issue_en == exp_en)
        else report_mismatch("issue_en", 64'(issue_en), 64'(exp_en));
    a_issue_uop: assert property (@(negedge clk) disable iff (rst)
        issue_en && exp_en |-> issue_uop == exp_uop)
        else report_mismatch("issue_uop", 64'(issue_uop), 64'(exp_uop));
    a_ready: assert property (@(negedge clk) disable iff (rst) ready == exp_ready)
        else report_mismatch("ready", 64'(ready), 64'(exp_ready));
    a_busy_quiet: assert property (@(negedge clk) disable iff (rst) lsu_busy |-> !issue_en)
        else report_mismatch("issue_en", 64'(issue_en), 64'h0);
    a_empty_idle: assert property (@(negedge clk) disable iff (rst)
        m_cnt == 0 |-> !issue_en && ready)
        else report_mismatch("issue_en/ready", 64'({issue_en, ready}), 64'h1);

    function automatic uop_t rand_uop(input logic st);
        logic [63:0] r;
        uop_t u;
        r = {$random(seed), $random(seed)};
        u = r[$bits(uop_t)-1:0];
        u.is_store = st;
        return u;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic dispatch(input logic two, input uop_t a, input logic a1, a2,
                            input uop_t b, input logic b1, b2);
        enq_req_0 = 1'b1;
        enq_req_1 = two;
        {uop_0, prs1_rdy_0, prs2_rdy_0} = {a, a1, a2};
        {uop_1, prs1_rdy_1, prs2_rdy_1} = {b, b1, b2};
        next_cycle();
        enq_req_0 = 1'b0;
        enq_req_1 = 1'b0;
    endtask

    task automatic wake(input int port, input logic [W-1:0] preg);
        wake_en[port] = 1'b1;
        wake_preg[port*W +: W] = preg;
        next_cycle();
        wake_en = '0;
    endtask

    task automatic wait_drained(input int limit);
        int n;
        n = 0;
        while (m_cnt != 0 && n < limit) begin
            next_cycle();
            n++;
        end
        if (m_cnt != 0) begin
            $display("*** FAILED ***");
            $fatal(1, "queue still holds %0d entries after %0d cycles", m_cnt, limit);
        end
    endtask

    task automatic wait_frozen(input int limit);
        int n;
        n = 0;
        while (ready && n < limit) begin
            dispatch(1'b1, rand_uop(1'b0), 1'b1, 1'b1, rand_uop(1'b0), 1'b1, 1'b1);
            n++;
        end
        if (ready) begin
            $display("*** FAILED ***");
            $fatal(1, "ready never dropped while filling the queue");
        end
    endtask

    initial begin
        uop_t u;
        {rst, flush, enq_req_0, enq_req_1, lsu_busy} = 5'b10000;
        {prs1_rdy_0, prs2_rdy_0, prs1_rdy_1, prs2_rdy_1} = 4'b0;
        {uop_0, uop_1, wake_en, wake_preg} = '0;
        repeat (5) @(posedge clk);
        #1 rst = 1'b0;
        repeat (3) next_cycle();

        // ready loads leave in order
        repeat (3) dispatch(1'b1, rand_uop(1'b0), 1'b1, 1'b1, rand_uop(1'b0), 1'b1, 1'b1);
        wait_drained(30);

        // waiting load gets passed by younger ready loads
        u = rand_uop(1'b0);
        u.prs1 = 6'h2a;
        dispatch(1'b0, u, 1'b0, 1'b1, u, 1'b0, 1'b0);
        dispatch(1'b1, rand_uop(1'b0), 1'b1, 1'b1, rand_uop(1'b0), 1'b1, 1'b1);
        repeat (4) next_cycle();
        wake(2, 6'h2a);
        wait_drained(20);

        // store barrier
        u = rand_uop(1'b1);
        u.prs2 = 6'h15;
        dispatch(1'b0, u, 1'b1, 1'b0, u, 1'b0, 1'b0);
        dispatch(1'b1, rand_uop(1'b0), 1'b1, 1'b1, rand_uop(1'b1), 1'b1, 1'b1);
        repeat (4) next_cycle();
        wake(0, 6'h15);
        wait_drained(20);

        // back-pressure and freeze, then flush a full queue
        lsu_busy = 1'b1;
        wait_frozen(10);
        repeat (3) dispatch(1'b1, rand_uop(1'b0), 1'b1, 1'b1, rand_uop(1'b0), 1'b1, 1'b1);
        lsu_busy = 1'b0;
        wait_drained(20);
        lsu_busy = 1'b1;
        wait_frozen(10);
        flush = 1'b1;
        next_cycle();
        flush = 1'b0;
        lsu_busy = 1'b0;
        repeat (3) next_cycle();

        // random traffic, then wake every register so the queue can drain
        repeat (120) begin
            enq_req_0 = $random(seed);
            enq_req_1 = $random(seed);
            lsu_busy  = ($random(seed) & 3) == 0;
            uop_0 = rand_uop(($random(seed) & 3) == 0);
            uop_1 = rand_uop(($random(seed) & 3) == 0);
            {prs1_rdy_0, prs2_rdy_0, prs1_rdy_1, prs2_rdy_1} = $random(seed);
            wake_en   = $random(seed);
            wake_preg = {$random(seed)};
            next_cycle();
        end
        {enq_req_0, enq_req_1, lsu_busy} = 3'b0;
        for (int r = 0; r < (1 << W); r += `LSU_WAKE_PORTS) begin
            wake_en = '1;
            for (int p = 0; p < `LSU_WAKE_PORTS; p++)
                wake_preg[p*W +: W] = W'(r + p);
            next_cycle();
        end
        wake_en = '0;
        wait_drained(40);

        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- list.f
+incdir+.
uop_pkg.sv
iq_pkg.sv
lsu_iq_entry.sv
lsu_iq_ctrl.sv
lsu_store_order.sv
lsu_issue_arbiter.sv
lsu_issue_unit.sv
tb_lsu_issue_unit.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the issue queue testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_lsu_issue_unit -Mdir obj_dir -f list.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vtb_lsu_issue_unit > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q '\*\*\* FAILED \*\*\*' "$LOG"; then
    echo "simulation reported a failure"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
echo "simulation finished clean"
